// ==== compile.f ====
+incdir+hdl
+incdir+verification
hdl/axi_types_pkg.sv
hdl/bridge_types_pkg.sv
hdl/axi_request_capture.sv
hdl/apb_transfer_engine.sv
hdl/axi_response_unit.sv
hdl/axi_apb_bridge.sv
verification/tb_axi_apb_bridge.sv

// ==== hdl/apb_bridge_macros.svh ====
`ifndef APB_BRIDGE_MACROS_SVH
`define APB_BRIDGE_MACROS_SVH

// bus widths shared by the AXI and APB sides
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_STRB_W 4

// AXI transaction id
`define BRIDGE_ID_W 11

// burst length field holds beats minus one, so 16 beats max
`define BRIDGE_LEN_W 4

// every beat is a full word
`define BRIDGE_BEAT_BYTES 4

`endif

// ==== hdl/apb_transfer_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apb_bridge_macros.svh"

module apb_transfer_engine
(
    input  wire                        ACLK,
    input  wire                        ARESET,
    input  wire                        cmd_valid,
    input  axi_types_pkg::op_e         cmd_op,
    input  wire  [`BRIDGE_ADDR_W-1:0]  cmd_addr,
    input  wire  [`BRIDGE_LEN_W-1:0]   cmd_len,
    output logic                       cmd_done,
    input  wire                        wbuf_valid,
    input  wire  [`BRIDGE_DATA_W-1:0]  wbuf_data,
    input  wire  [`BRIDGE_STRB_W-1:0]  wbuf_strb,
    output logic                       wbuf_take,
    output logic [`BRIDGE_ADDR_W-1:0]  PADDR,
    output logic                       PSEL,
    output logic                       PENABLE,
    output logic                       PWRITE,
    output logic [`BRIDGE_DATA_W-1:0]  PWDATA,
    output logic [`BRIDGE_STRB_W-1:0]  PSTRB,
    input  wire                        PREADY,
    input  wire  [`BRIDGE_DATA_W-1:0]  PRDATA,
    input  wire                        PSLVERR,
    input  wire                        rsp_ready,
    output logic                       beat_done,
    output logic [`BRIDGE_DATA_W-1:0]  beat_data,
    output logic                       beat_err,
    output logic                       beat_last
);

    bridge_types_pkg::engine_state_e  state;
    bridge_types_pkg::engine_state_e  state_nxt;
    logic [`BRIDGE_ADDR_W-1:0]        beat_addr;
    logic [`BRIDGE_LEN_W-1:0]         beat_cnt;   // beats left after this one
    logic                             is_write;
    logic                             start;
    logic                             hand_off;

    assign is_write = (cmd_op == axi_types_pkg::OP_WRITE);
    // cmd_done still high means the slot clears this cycle
    assign start    = (state == bridge_types_pkg::ST_IDLE) && cmd_valid && !cmd_done;
    assign hand_off = (state == bridge_types_pkg::ST_WAIT_RSP) && rsp_ready;

    assign beat_done = hand_off;
    assign beat_last = (beat_cnt == '0);

    // write beat moves from the capture buffer into PWDATA on entry to setup
    assign wbuf_take = is_write && wbuf_valid
                       && ((state == bridge_types_pkg::ST_WAIT_WDATA)
                           || (hand_off && !beat_last));

    assign PADDR   = beat_addr;
    assign PSEL    = (state == bridge_types_pkg::ST_SETUP)
                     || (state == bridge_types_pkg::ST_ACCESS);
    assign PENABLE = (state == bridge_types_pkg::ST_ACCESS);
    assign PWRITE  = is_write;

    ////////////////////////////////////////////////////////////////////////////
    // per-beat FSM
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        state_nxt = state;
        case (state)
            bridge_types_pkg::ST_IDLE:
                if (start)
                begin
                    if (is_write)
                        state_nxt = bridge_types_pkg::ST_WAIT_WDATA;
                    else
                        state_nxt = bridge_types_pkg::ST_SETUP;
                end
            bridge_types_pkg::ST_WAIT_WDATA:
                if (wbuf_valid)
                    state_nxt = bridge_types_pkg::ST_SETUP;
            bridge_types_pkg::ST_SETUP:
                state_nxt = bridge_types_pkg::ST_ACCESS;   // setup is one cycle
            bridge_types_pkg::ST_ACCESS:
                if (PREADY)
                    state_nxt = bridge_types_pkg::ST_WAIT_RSP;
            bridge_types_pkg::ST_WAIT_RSP:
                if (rsp_ready)
                begin
                    if (beat_last)
                        state_nxt = bridge_types_pkg::ST_IDLE;
                    else if (!is_write || wbuf_valid)
                        state_nxt = bridge_types_pkg::ST_SETUP;
                    else
                        state_nxt = bridge_types_pkg::ST_WAIT_WDATA;
                end
            default:
                state_nxt = bridge_types_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESET)
    begin
        if (!ARESET)
        begin
            state    <= bridge_types_pkg::ST_IDLE;
            cmd_done <= 1'b0;
            beat_cnt <= '0;
        end
        else
        begin
            state    <= state_nxt;
            cmd_done <= hand_off && beat_last;   // one cycle after the last beat
            if (start)
                beat_cnt <= cmd_len;
            else if (hand_off && !beat_last)
                beat_cnt <= beat_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // address, write data and sampled read data
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK)
    begin
        if (start)
            beat_addr <= cmd_addr;
        else if (hand_off)
            beat_addr <= beat_addr + `BRIDGE_BEAT_BYTES;   // next word
        if (wbuf_take)
        begin
            PWDATA <= wbuf_data;
            PSTRB  <= wbuf_strb;
        end
        if ((state == bridge_types_pkg::ST_ACCESS) && PREADY)
        begin
            beat_data <= PRDATA;
            beat_err  <= PSLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axi_apb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apb_bridge_macros.svh"

module axi_apb_bridge
(
    input  wire                        ACLK,
    input  wire                        ARESET,
    input  wire  [`BRIDGE_ID_W-1:0]    ARID,
    input  wire  [`BRIDGE_ADDR_W-1:0]  ARADDR,
    input  wire  [`BRIDGE_LEN_W-1:0]   ARLEN,
    input  wire                        ARVALID,
    output logic                       ARREADY,
    input  wire  [`BRIDGE_ID_W-1:0]    AWID,
    input  wire  [`BRIDGE_ADDR_W-1:0]  AWADDR,
    input  wire  [`BRIDGE_LEN_W-1:0]   AWLEN,
    input  wire                        AWVALID,
    output logic                       AWREADY,
    input  wire  [`BRIDGE_DATA_W-1:0]  WDATA,
    input  wire  [`BRIDGE_STRB_W-1:0]  WSTRB,
    input  wire                        WVALID,
    output logic                       WREADY,
    output logic [`BRIDGE_ID_W-1:0]    RID,
    output logic [`BRIDGE_DATA_W-1:0]  RDATA,
    output axi_types_pkg::resp_e       RRESP,
    output logic                       RLAST,
    output logic                       RVALID,
    input  wire                        RREADY,
    output logic [`BRIDGE_ID_W-1:0]    BID,
    output axi_types_pkg::resp_e       BRESP,
    output logic                       BVALID,
    input  wire                        BREADY,
    output logic [`BRIDGE_ADDR_W-1:0]  PADDR,
    output logic                       PSEL,
    output logic                       PENABLE,
    output logic                       PWRITE,
    output logic [`BRIDGE_DATA_W-1:0]  PWDATA,
    output logic [`BRIDGE_STRB_W-1:0]  PSTRB,
    input  wire                        PREADY,
    input  wire  [`BRIDGE_DATA_W-1:0]  PRDATA,
    input  wire                        PSLVERR
);

    // capture to engine and response unit
    logic                       cmd_valid;
    axi_types_pkg::op_e         cmd_op;
    logic [`BRIDGE_ADDR_W-1:0]  cmd_addr;
    logic [`BRIDGE_LEN_W-1:0]   cmd_len;
    logic [`BRIDGE_ID_W-1:0]    cmd_id;
    logic                       cmd_done;
    logic                       wbuf_valid;
    logic [`BRIDGE_DATA_W-1:0]  wbuf_data;
    logic [`BRIDGE_STRB_W-1:0]  wbuf_strb;
    logic                       wbuf_take;
    // engine to response unit
    logic                       beat_done;
    logic [`BRIDGE_DATA_W-1:0]  beat_data;
    logic                       beat_err;
    logic                       beat_last;
    logic                       rsp_ready;

    axi_request_capture u_axi_request_capture (.*);

    apb_transfer_engine u_apb_transfer_engine (.*);

    axi_response_unit u_axi_response_unit (.*);

endmodule

`default_nettype wire

// ==== hdl/axi_request_capture.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apb_bridge_macros.svh"

module axi_request_capture
(
    input  wire                        ACLK,
    input  wire                        ARESET,
    input  wire  [`BRIDGE_ID_W-1:0]    ARID,
    input  wire  [`BRIDGE_ADDR_W-1:0]  ARADDR,
    input  wire  [`BRIDGE_LEN_W-1:0]   ARLEN,
    input  wire                        ARVALID,
    output logic                       ARREADY,
    input  wire  [`BRIDGE_ID_W-1:0]    AWID,
    input  wire  [`BRIDGE_ADDR_W-1:0]  AWADDR,
    input  wire  [`BRIDGE_LEN_W-1:0]   AWLEN,
    input  wire                        AWVALID,
    output logic                       AWREADY,
    input  wire  [`BRIDGE_DATA_W-1:0]  WDATA,
    input  wire  [`BRIDGE_STRB_W-1:0]  WSTRB,
    input  wire                        WVALID,
    output logic                       WREADY,
    input  wire                        cmd_done,
    input  wire                        wbuf_take,
    output logic                       cmd_valid,
    output axi_types_pkg::op_e         cmd_op,
    output logic [`BRIDGE_ADDR_W-1:0]  cmd_addr,
    output logic [`BRIDGE_LEN_W-1:0]   cmd_len,
    output logic [`BRIDGE_ID_W-1:0]    cmd_id,
    output logic                       wbuf_valid,
    output logic [`BRIDGE_DATA_W-1:0]  wbuf_data,
    output logic [`BRIDGE_STRB_W-1:0]  wbuf_strb
);

    logic                      ar_hs;
    logic                      aw_hs;
    logic                      w_hs;
    logic [`BRIDGE_LEN_W-1:0]  w_cnt;    // W beats taken in this burst
    logic                      w_done;   // last W beat seen

    assign ARREADY = !cmd_valid;
    assign AWREADY = !cmd_valid && !ARVALID;   // read wins a tie
    assign WREADY  = cmd_valid && (cmd_op == axi_types_pkg::OP_WRITE)
                     && !wbuf_valid && !w_done;

    assign ar_hs = ARVALID && ARREADY;
    assign aw_hs = AWVALID && AWREADY;
    assign w_hs  = WVALID && WREADY;

    ////////////////////////////////////////////////////////////////////////////
    // one-entry command slot
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK or negedge ARESET)
    begin
        if (!ARESET)
        begin
            cmd_valid <= 1'b0;
            cmd_op    <= axi_types_pkg::OP_READ;
        end
        else if (ar_hs)
        begin
            cmd_valid <= 1'b1;
            cmd_op    <= axi_types_pkg::OP_READ;
        end
        else if (aw_hs)
        begin
            cmd_valid <= 1'b1;
            cmd_op    <= axi_types_pkg::OP_WRITE;
        end
        else if (cmd_done)
            cmd_valid <= 1'b0;   // engine finished the burst
    end

    always_ff @(posedge ACLK)
    begin
        if (ar_hs)
        begin
            cmd_addr <= ARADDR;
            cmd_len  <= ARLEN;
            cmd_id   <= ARID;
        end
        else if (aw_hs)
        begin
            cmd_addr <= AWADDR;
            cmd_len  <= AWLEN;
            cmd_id   <= AWID;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write beat buffer and W beat count
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK or negedge ARESET)
    begin
        if (!ARESET)
        begin
            w_cnt      <= '0;
            w_done     <= 1'b0;
            wbuf_valid <= 1'b0;
        end
        else
        begin
            if (ar_hs || aw_hs)
            begin
                w_cnt  <= '0;
                w_done <= 1'b0;
            end
            else if (w_hs)
            begin
                if (w_cnt == cmd_len)
                    w_done <= 1'b1;   // closes WREADY
                else
                    w_cnt <= w_cnt + 1'b1;
            end
            if (w_hs)
                wbuf_valid <= 1'b1;
            else if (wbuf_take)
                wbuf_valid <= 1'b0;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (w_hs)
        begin
            wbuf_data <= WDATA;
            wbuf_strb <= WSTRB;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axi_response_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apb_bridge_macros.svh"

module axi_response_unit
(
    input  wire                        ACLK,
    input  wire                        ARESET,
    input  axi_types_pkg::op_e         cmd_op,
    input  wire  [`BRIDGE_ID_W-1:0]    cmd_id,
    input  wire                        beat_done,
    input  wire  [`BRIDGE_DATA_W-1:0]  beat_data,
    input  wire                        beat_err,
    input  wire                        beat_last,
    output logic                       rsp_ready,
    output logic [`BRIDGE_ID_W-1:0]    RID,
    output logic [`BRIDGE_DATA_W-1:0]  RDATA,
    output axi_types_pkg::resp_e       RRESP,
    output logic                       RLAST,
    output logic                       RVALID,
    input  wire                        RREADY,
    output logic [`BRIDGE_ID_W-1:0]    BID,
    output axi_types_pkg::resp_e       BRESP,
    output logic                       BVALID,
    input  wire                        BREADY
);

    logic  is_read;
    logic  err_sticky;   // any failed beat so far in this write

    assign is_read = (cmd_op == axi_types_pkg::OP_READ);

    // middle write beats only touch the sticky flag
    assign rsp_ready = is_read ? !RVALID : (!beat_last || !BVALID);

    ////////////////////////////////////////////////////////////////////////////
    // R channel
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK or negedge ARESET)
    begin
        if (!ARESET)
            RVALID <= 1'b0;
        else if (beat_done && is_read)
            RVALID <= 1'b1;
        else if (RREADY)
            RVALID <= 1'b0;
    end

    always_ff @(posedge ACLK)
    begin
        if (beat_done && is_read)
        begin
            RID   <= cmd_id;
            RDATA <= beat_data;
            RLAST <= beat_last;
            if (beat_err)
                RRESP <= axi_types_pkg::SLVERR;
            else
                RRESP <= axi_types_pkg::OKAY;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // B channel with one response per burst
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK or negedge ARESET)
    begin
        if (!ARESET)
        begin
            BVALID     <= 1'b0;
            err_sticky <= 1'b0;
        end
        else
        begin
            if (beat_done && !is_read && beat_last)
                BVALID <= 1'b1;
            else if (BREADY)
                BVALID <= 1'b0;   // also while a middle beat of the next write lands
            if (beat_done && !is_read)
            begin
                if (beat_last)
                    err_sticky <= 1'b0;   // ready for the next burst
                else
                    err_sticky <= err_sticky || beat_err;
            end
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (beat_done && !is_read && beat_last)
        begin
            BID <= cmd_id;
            if (err_sticky || beat_err)
                BRESP <= axi_types_pkg::SLVERR;
            else
                BRESP <= axi_types_pkg::OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axi_types_pkg.sv ====
`default_nettype none

package axi_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // response codes on RRESP and BRESP
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0]
    {
        OKAY   = 2'b00,
        SLVERR = 2'b10   // completer raised PSLVERR
    } resp_e;

    ////////////////////////////////////////////////////////////////////////////
    // command direction held in the command slot
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

endpackage

`default_nettype wire

// ==== hdl/bridge_types_pkg.sv ====
`default_nettype none

package bridge_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // APB transfer engine states
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0]
    {
        ST_IDLE       = 3'd0,   // no command in progress
        ST_WAIT_WDATA = 3'd1,   // write beat not yet buffered
        ST_SETUP      = 3'd2,   // PSEL high, PENABLE low
        ST_ACCESS     = 3'd3,   // PSEL and PENABLE high until PREADY
        ST_WAIT_RSP   = 3'd4    // beat held for the response unit
    } engine_state_e;

endpackage

`default_nettype wire

// ==== verification/tb_bridge_checks.svh ====
`ifndef TB_BRIDGE_CHECKS_SVH
`define TB_BRIDGE_CHECKS_SVH

localparam int WAIT_LIMIT = 400;   // cycles allowed in any single wait loop

int error_count   = 0;
int timeout_count = 0;

////////////////////////////////////////////////////////////////////////////
// typed compares
////////////////////////////////////////////////////////////////////////////
task automatic check_resp(input string what, input axi_types_pkg::resp_e got,
                          input axi_types_pkg::resp_e exp);
    if (got !== exp)
    begin
        $display("error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        error_count++;
    end
endtask

task automatic check_data(input string what, input logic [`BRIDGE_DATA_W-1:0] got,
                          input logic [`BRIDGE_DATA_W-1:0] exp);
    if (got !== exp)
    begin
        $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        error_count++;
    end
endtask

task automatic check_id(input string what, input logic [`BRIDGE_ID_W-1:0] got,
                        input logic [`BRIDGE_ID_W-1:0] exp);
    if (got !== exp)
    begin
        $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        error_count++;
    end
endtask

task automatic check_addr(input string what, input logic [`BRIDGE_ADDR_W-1:0] got,
                          input logic [`BRIDGE_ADDR_W-1:0] exp);
    if (got !== exp)
    begin
        $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        error_count++;
    end
endtask

task automatic check_strb(input string what, input logic [`BRIDGE_STRB_W-1:0] got,
                          input logic [`BRIDGE_STRB_W-1:0] exp);
    if (got !== exp)
    begin
        $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        error_count++;
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        error_count++;
    end
endtask

// one falling edge of a bounded wait that gives up past WAIT_LIMIT
task automatic next_cycle(input string what, inout int cycles);
    bridge_types_pkg::engine_state_e st;
    cycles++;
    if (cycles > WAIT_LIMIT)
    begin
        st = u_axi_apb_bridge.u_apb_transfer_engine.state;
        $display("gave up at %0t after %0d cycles waiting for %s, engine in %s",
                 $time, WAIT_LIMIT, what, st.name());
        timeout_count++;
        end_run();
    end
    else
        @(negedge ACLK);
endtask

`endif

// ==== verification/tb_axi_apb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apb_bridge_macros.svh"

module tb_axi_apb_bridge;

    localparam int PERIOD = 40;

    logic                       ACLK;
    logic                       ARESET;
    logic [`BRIDGE_ID_W-1:0]    ARID;
    logic [`BRIDGE_ADDR_W-1:0]  ARADDR;
    logic [`BRIDGE_LEN_W-1:0]   ARLEN;
    logic                       ARVALID;
    logic                       ARREADY;
    logic [`BRIDGE_ID_W-1:0]    AWID;
    logic [`BRIDGE_ADDR_W-1:0]  AWADDR;
    logic [`BRIDGE_LEN_W-1:0]   AWLEN;
    logic                       AWVALID;
    logic                       AWREADY;
    logic [`BRIDGE_DATA_W-1:0]  WDATA;
    logic [`BRIDGE_STRB_W-1:0]  WSTRB;
    logic                       WVALID;
    logic                       WREADY;
    logic [`BRIDGE_ID_W-1:0]    RID;
    logic [`BRIDGE_DATA_W-1:0]  RDATA;
    axi_types_pkg::resp_e       RRESP;
    logic                       RLAST;
    logic                       RVALID;
    logic                       RREADY;
    logic [`BRIDGE_ID_W-1:0]    BID;
    axi_types_pkg::resp_e       BRESP;
    logic                       BVALID;
    logic                       BREADY;
    logic [`BRIDGE_ADDR_W-1:0]  PADDR;
    logic                       PSEL;
    logic                       PENABLE;
    logic                       PWRITE;
    logic [`BRIDGE_DATA_W-1:0]  PWDATA;
    logic [`BRIDGE_STRB_W-1:0]  PSTRB;
    logic                       PREADY;
    logic [`BRIDGE_DATA_W-1:0]  PRDATA;
    logic                       PSLVERR;

    logic [`BRIDGE_DATA_W-1:0]  apb_mem [0:4095];   // completer storage indexed by PADDR[13:2]
    logic [`BRIDGE_DATA_W-1:0]  ref_mem [0:4095];   // reference copy
    logic [`BRIDGE_ADDR_W-1:0]  exp_addr_q [$];     // APB setups still to come
    logic                       exp_write_q [$];
    logic [`BRIDGE_STRB_W-1:0]  exp_strb_q [$];     // strobes of write setups still to come
    integer                     seed;
    logic [31:0]                apb_rnd;
    logic [1:0]                 wait_left;          // PREADY-low cycles left
    logic                       stall_en;           // random RREADY/BREADY

    `include "tb_bridge_checks.svh"

    axi_apb_bridge u_axi_apb_bridge (.*);

    initial
    begin
        ACLK = 1'b0;
        forever
            #(PERIOD / 2) ACLK = ~ACLK;
    end

    function automatic logic [`BRIDGE_DATA_W-1:0] fill_word(input int idx);
        logic [11:0] w;
        w = idx[11:0];
        return {w, 8'h5a, ~w};
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic draw_ready();
        logic [31:0] rnd;
        rnd = $random(seed);
        return !stall_en || rnd[0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB completer with word memory and error region at address bit 12
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_setup();
        logic exp_wr;
        if (exp_addr_q.size() == 0)
        begin
            $display("APB setup at address %h came when no transfer was expected", PADDR);
            error_count++;
        end
        else
        begin
            exp_wr = exp_write_q.pop_front();
            check_addr("PADDR at setup", PADDR, exp_addr_q.pop_front());
            check_flag("PWRITE at setup", PWRITE, exp_wr);
            if (exp_wr)
                check_strb("PSTRB at setup", PSTRB, exp_strb_q.pop_front());
        end
    endtask

    always @(negedge ACLK)
    begin
        PREADY  = 1'b0;
        PSLVERR = 1'b0;
        PRDATA  = '0;
        if (PSEL && !PENABLE)
        begin
            check_setup();
            apb_rnd   = $random(seed);
            wait_left = apb_rnd[1:0];   // 0 to 3 wait cycles
        end
        else if (PSEL && (wait_left != 2'd0))
            wait_left = wait_left - 1'b1;
        else if (PSEL)
        begin
            PREADY  = 1'b1;   // access ends on the next rising edge
            PSLVERR = PADDR[12];
            if (!PADDR[12])
            begin
                PRDATA = apb_mem[PADDR[13:2]];
                if (PWRITE)
                    apb_mem[PADDR[13:2]] = PWDATA;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // AXI transactions with reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic expect_burst(input logic [`BRIDGE_ADDR_W-1:0] addr,
                                input logic [`BRIDGE_LEN_W-1:0] len, input logic wr);
        for (int i = 0; i <= int'(len); i++)
        begin
            exp_addr_q.push_back(addr + 4 * i);
            exp_write_q.push_back(wr);
        end
    endtask

    task automatic check_setups_done(input string what);
        if (exp_addr_q.size() != 0)
        begin
            $display("%0d expected APB transfers never happened during %s",
                     exp_addr_q.size(), what);
            error_count++;
        end
        exp_addr_q.delete();
        exp_write_q.delete();
        exp_strb_q.delete();
    endtask

    task automatic do_write(input logic [`BRIDGE_ID_W-1:0] id,
                            input logic [`BRIDGE_ADDR_W-1:0] addr,
                            input logic [`BRIDGE_LEN_W-1:0] len);
        logic [`BRIDGE_DATA_W-1:0]  data [0:15];
        logic [`BRIDGE_STRB_W-1:0]  strb [0:15];
        logic [`BRIDGE_ADDR_W-1:0]  a;
        logic [31:0]                rnd;
        axi_types_pkg::resp_e       exp_resp;
        int                         cycles;
        exp_resp = axi_types_pkg::OKAY;
        for (int i = 0; i <= int'(len); i++)
        begin
            a       = addr + 4 * i;
            data[i] = rand_word();
            rnd     = rand_word();
            strb[i] = rnd[`BRIDGE_STRB_W-1:0];
            exp_strb_q.push_back(strb[i]);
            if (a[12])
                exp_resp = axi_types_pkg::SLVERR;   // one bad beat fails the burst
            else
                ref_mem[a[13:2]] = data[i];
        end
        AWID    = id;
        AWADDR  = addr;
        AWLEN   = len;
        AWVALID = 1'b1;
        cycles  = 0;
        #1;   // AWREADY depends on ARVALID combinationally
        while (!AWREADY)
            next_cycle("AWREADY", cycles);
        @(negedge ACLK);
        AWVALID = 1'b0;
        for (int i = 0; i <= int'(len); i++)
        begin
            WDATA  = data[i];
            WSTRB  = strb[i];
            WVALID = 1'b1;
            cycles = 0;
            while (!WREADY)
                next_cycle("WREADY", cycles);
            @(negedge ACLK);
        end
        WVALID = 1'b0;
        cycles = 0;
        BREADY = draw_ready();
        while (!(BVALID && BREADY))
        begin
            next_cycle("BVALID", cycles);
            BREADY = draw_ready();
        end
        check_id("BID", BID, id);
        check_resp("BRESP", BRESP, exp_resp);
        @(negedge ACLK);
        BREADY = 1'b0;
        for (int i = 0; i <= int'(len); i++)
        begin
            a = addr + 4 * i;
            check_data("completer memory", apb_mem[a[13:2]], ref_mem[a[13:2]]);
        end
    endtask

    task automatic do_read(input logic [`BRIDGE_ID_W-1:0] id,
                           input logic [`BRIDGE_ADDR_W-1:0] addr,
                           input logic [`BRIDGE_LEN_W-1:0] len);
        logic [`BRIDGE_ADDR_W-1:0]  a;
        axi_types_pkg::resp_e       exp_resp;
        int                         cycles;
        ARID    = id;
        ARADDR  = addr;
        ARLEN   = len;
        ARVALID = 1'b1;
        cycles  = 0;
        while (!ARREADY)
            next_cycle("ARREADY", cycles);
        @(negedge ACLK);
        ARVALID = 1'b0;
        for (int i = 0; i <= int'(len); i++)
        begin
            a        = addr + 4 * i;
            exp_resp = a[12] ? axi_types_pkg::SLVERR : axi_types_pkg::OKAY;
            cycles   = 0;
            RREADY   = draw_ready();
            while (!(RVALID && RREADY))
            begin
                next_cycle("RVALID", cycles);
                RREADY = draw_ready();
            end
            check_id("RID", RID, id);
            check_resp("RRESP", RRESP, exp_resp);
            check_flag("RLAST", RLAST, i == int'(len));
            if (!a[12])
                check_data("RDATA", RDATA, ref_mem[a[13:2]]);
            @(negedge ACLK);
        end
        RREADY = 1'b0;
    endtask

    // write a burst and read it back from the same address
    task automatic run_pair(input logic [`BRIDGE_ADDR_W-1:0] addr,
                            input logic [`BRIDGE_LEN_W-1:0] len,
                            input logic [`BRIDGE_ID_W-1:0] wid,
                            input logic [`BRIDGE_ID_W-1:0] rid);
        expect_burst(addr, len, 1'b1);
        do_write(wid, addr, len);
        check_setups_done("write burst");
        expect_burst(addr, len, 1'b0);
        do_read(rid, addr, len);
        check_setups_done("read burst");
    endtask

    task automatic end_run();
        $display("run complete with %0d errors and %0d timeouts", error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0))
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        logic [31:0] rnd;
        seed      = 32'h2171bbfe;
        ARESET    = 1'b0;
        ARID      = '0;
        ARADDR    = '0;
        ARLEN     = '0;
        ARVALID   = 1'b0;
        AWID      = '0;
        AWADDR    = '0;
        AWLEN     = '0;
        AWVALID   = 1'b0;
        WDATA     = '0;
        WSTRB     = '0;
        WVALID    = 1'b0;
        RREADY    = 1'b0;
        BREADY    = 1'b0;
        PREADY    = 1'b0;
        PRDATA    = '0;
        PSLVERR   = 1'b0;
        wait_left = 2'd0;
        stall_en  = 1'b0;
        for (int i = 0; i < 4096; i++)
        begin
            apb_mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (16) @(negedge ACLK);
        ARESET = 1'b1;
        @(negedge ACLK);

        // single beat outside the error region
        rnd = rand_word();
        run_pair({18'h0, rnd[13], 1'b0, rnd[11:2], 2'b00}, 4'd0, 11'h123, 11'h456);

        // random bursts that may cross into bit 12
        for (int n = 0; n < 20; n++)
        begin
            rnd = rand_word();
            run_pair({18'h0, rnd[27:16], 2'b00}, rnd[3:0], rnd[14:4], rnd[30:20]);
        end

        run_pair(32'h0000_0ff4, 4'd7, 11'h2a5, 11'h35a);   // 3 good beats then 5 bad

        // same traffic under R and B back-pressure
        stall_en = 1'b1;
        run_pair(32'h0000_0ff8, 4'd5, 11'h0f1, 11'h1f0);
        for (int n = 0; n < 20; n++)
        begin
            rnd = rand_word();
            run_pair({18'h0, rnd[27:16], 2'b00}, rnd[3:0], rnd[14:4], rnd[30:20]);
        end
        stall_en = 1'b0;

        // read goes to APB first when AR and AW arrive together
        expect_burst(32'h0000_0200, 4'd0, 1'b0);
        expect_burst(32'h0000_2400, 4'd1, 1'b1);
        fork
            do_read(11'h0a1, 32'h0000_0200, 4'd0);
            do_write(11'h0b2, 32'h0000_2400, 4'd1);
        join
        check_setups_done("simultaneous AR and AW");
        expect_burst(32'h0000_2400, 4'd1, 1'b0);
        do_read(11'h0c3, 32'h0000_2400, 4'd1);
        check_setups_done("read back after simultaneous AR and AW");

        end_run();
    end

endmodule

`default_nettype wire
